//--- logic/dcache_pkg.sv
package dcache_pkg;

    // cache geometry
    localparam int unsigned WAYS       = 2;
    localparam int unsigned SETS       = 16;
    localparam int unsigned LINE_WORDS = 4;

    localparam int unsigned ADDR_W     = 32;
    localparam int unsigned WORD_W     = 32;
    localparam int unsigned STRB_W     = WORD_W / 8;
    localparam int unsigned LINE_W     = LINE_WORDS * WORD_W;

    // address fields from the top down are tag | index | word | byte
    localparam int unsigned OFFSET_W   = 4;
    localparam int unsigned INDEX_W    = 4;
    localparam int unsigned TAG_W      = ADDR_W - INDEX_W - OFFSET_W;
    localparam int unsigned WORD_SEL_W = $clog2(LINE_WORDS);
    localparam int unsigned WAY_W      = $clog2(WAYS);

    typedef logic [WORD_W-1:0]     word_t;

    // word 0 sits in the low bits
    typedef logic [LINE_W-1:0]     line_t;

    typedef logic [TAG_W-1:0]      tag_t;
    typedef logic [INDEX_W-1:0]    index_t;
    typedef logic [WORD_SEL_W-1:0] word_sel_t;
    typedef logic [WAY_W-1:0]      way_t;

    // miss handling walk
    typedef enum logic [2:0] {
        LOOKUP,
        MISS_DIRTY,
        WRITEBACK,
        MISS_CLEAN,
        REFILL,
        REFILL_DONE
    } cache_state_e;

endpackage

//--- logic/dcache_req_stage.sv
`timescale 1ns/1ps

module dcache_req_stage (
    input  logic                           clk_g,
    input  logic                           resetn,
    input  logic                           req,
    input  logic                           wr,
    input  logic [dcache_pkg::ADDR_W-1:0]  addr,
    input  logic [dcache_pkg::STRB_W-1:0]  wstrb,
    input  dcache_pkg::word_t              wdata,
    input  logic                           lookup_ready,
    input  logic                           data_ok,
    output logic                           addr_ok,
    output logic                           pending,
    output logic                           req_wr,
    output dcache_pkg::tag_t               req_tag,
    output dcache_pkg::index_t             req_index,
    output dcache_pkg::word_sel_t          req_word,
    output logic [dcache_pkg::STRB_W-1:0]  req_wstrb,
    output dcache_pkg::word_t              req_wdata
);

    import dcache_pkg::*;

    logic accept;

    // the controller decides when a new lookup may start
    assign addr_ok = req && lookup_ready;
    assign accept  = req && addr_ok;

    // a new accept wins over the finishing data_ok
    always_ff @(posedge clk_g) begin
        if (!resetn) begin
            pending <= 1'b0;
        end else if (accept) begin
            pending <= 1'b1;
        end else if (data_ok) begin
            pending <= 1'b0;
        end
    end

    // request payload with the address split into its fields
    always_ff @(posedge clk_g) begin
        if (accept) begin
            req_wr    <= wr;
            req_tag   <= addr[ADDR_W-1 -: TAG_W];
            req_index <= addr[OFFSET_W +: INDEX_W];
            req_word  <= addr[OFFSET_W-1 -: WORD_SEL_W];
            req_wstrb <= wstrb;
            req_wdata <= wdata;
        end
    end

endmodule

//--- logic/dcache_ways.sv
`timescale 1ns/1ps

module dcache_ways (
    input  logic                           clk_g,
    input  logic                           resetn,
    input  dcache_pkg::tag_t               req_tag,
    input  dcache_pkg::index_t             req_index,
    input  dcache_pkg::word_sel_t          req_word,
    input  logic [dcache_pkg::STRB_W-1:0]  req_wstrb,
    input  dcache_pkg::word_t              req_wdata,
    input  logic                           store_en,
    input  logic                           refill_en,
    input  dcache_pkg::line_t              ret_data,
    output logic                           hit,
    output logic                           victim_dirty,
    output dcache_pkg::tag_t               victim_tag,
    output dcache_pkg::line_t              victim_line,
    output dcache_pkg::word_t              rd_word
);

    import dcache_pkg::*;

    // storage
    line_t           data_q  [WAYS][SETS];
    tag_t            tag_q   [WAYS][SETS];
    logic [WAYS-1:0] valid_q [SETS];
    logic [WAYS-1:0] dirty_q [SETS];

    // lru_q holds the way to replace next
    way_t            lru_q   [SETS];

    logic [WAYS-1:0] hit_vec;
    way_t            hit_way;
    way_t            victim;
    line_t           hit_line;
    word_t           merged_word;

    for (genvar w = 0; w < WAYS; w++) begin : g_tag_cmp
        assign hit_vec[w] = valid_q[req_index][w] && (tag_q[w][req_index] == req_tag);
    end

    assign hit = |hit_vec;

    always_comb begin
        hit_way = '0;
        for (int w = 0; w < WAYS; w++) begin
            if (hit_vec[w]) begin
                hit_way = way_t'(w);
            end
        end
    end

    assign hit_line = data_q[hit_way][req_index];
    assign rd_word  = hit_line[req_word*WORD_W +: WORD_W];

    // victim comes straight from the set's lru bit
    assign victim       = lru_q[req_index];
    assign victim_dirty = dirty_q[req_index][victim];
    assign victim_tag   = tag_q[victim][req_index];
    assign victim_line  = data_q[victim][req_index];

    // byte merge of store data into the hit word
    always_comb begin
        for (int b = 0; b < STRB_W; b++) begin
            merged_word[8*b +: 8] = req_wstrb[b] ? req_wdata[8*b +: 8] : rd_word[8*b +: 8];
        end
    end

    always_ff @(posedge clk_g) begin
        if (refill_en) begin
            data_q[victim][req_index] <= ret_data;
            tag_q[victim][req_index]  <= req_tag;
        end else if (store_en) begin
            data_q[hit_way][req_index][req_word*WORD_W +: WORD_W] <= merged_word;
        end
    end

    always_ff @(posedge clk_g) begin
        if (!resetn) begin
            for (int s = 0; s < SETS; s++) begin
                valid_q[s] <= '0;
                dirty_q[s] <= '0;
                lru_q[s]   <= '0;
            end
        end else if (refill_en) begin
            // fresh line is clean and most recent
            valid_q[req_index][victim] <= 1'b1;
            dirty_q[req_index][victim] <= 1'b0;
            lru_q[req_index]           <= ~victim;
        end else begin
            if (store_en) begin
                dirty_q[req_index][hit_way] <= 1'b1;
            end
            if (hit) begin
                lru_q[req_index] <= ~hit_way;
            end
        end
    end

endmodule

//--- logic/dcache_ctrl.sv
`timescale 1ns/1ps

module dcache_ctrl (
    input  logic clk_g,
    input  logic resetn,
    input  logic pending,
    input  logic req_wr,
    input  logic hit,
    input  logic victim_dirty,
    input  logic rd_rdy,
    input  logic ret_valid,
    input  logic wr_rdy,
    input  logic wr_bvalid,
    output logic lookup_ready,
    output logic store_en,
    output logic refill_en,
    output logic rd_req,
    output logic wr_req,
    output logic data_ok
);

    import dcache_pkg::*;

    cache_state_e state;
    cache_state_e state_next;

    always_ff @(posedge clk_g) begin
        if (!resetn) begin
            state <= LOOKUP;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            LOOKUP: begin
                if (pending && !hit) begin
                    state_next = victim_dirty ? MISS_DIRTY : MISS_CLEAN;
                end
            end
            MISS_DIRTY: begin
                if (wr_rdy) begin
                    state_next = WRITEBACK;
                end
            end
            WRITEBACK: begin
                // line must be in memory before the refill read goes out
                if (wr_bvalid) begin
                    state_next = MISS_CLEAN;
                end
            end
            MISS_CLEAN: begin
                if (rd_rdy) begin
                    state_next = REFILL;
                end
            end
            REFILL: begin
                if (ret_valid) begin
                    state_next = REFILL_DONE;
                end
            end
            REFILL_DONE: begin
                state_next = LOOKUP;
            end
            default: begin
                state_next = LOOKUP;
            end
        endcase
    end

    // the held request replays its lookup after REFILL_DONE,
    // so no new request may slip in during that cycle
    assign lookup_ready = (state_next == LOOKUP) && (state != REFILL_DONE);

    assign data_ok   = (state == LOOKUP) && pending && hit;
    assign store_en  = data_ok && req_wr;
    assign refill_en = (state == REFILL) && ret_valid;

    // memory requests are level held in their wait states
    assign rd_req = (state == MISS_CLEAN);
    assign wr_req = (state == MISS_DIRTY);

endmodule

//--- logic/dcache_mem_port.sv
`timescale 1ns/1ps

module dcache_mem_port (
    input  dcache_pkg::tag_t               req_tag,
    input  dcache_pkg::index_t             req_index,
    input  dcache_pkg::tag_t               victim_tag,
    input  dcache_pkg::line_t              victim_line,
    output logic [dcache_pkg::ADDR_W-1:0]  rd_addr,
    output logic [dcache_pkg::ADDR_W-1:0]  wr_addr,
    output dcache_pkg::line_t              wr_data
);

    import dcache_pkg::*;

    // line aligned byte address of a tag in a set
    function automatic logic [ADDR_W-1:0] line_addr(
        input tag_t   tag,
        input index_t index
    );
        return {tag, index, {OFFSET_W{1'b0}}};
    endfunction

    // refill fetches the line the request asked for
    assign rd_addr = line_addr(req_tag, req_index);

    // writeback goes to where the victim came from,
    // the set is shared with the request
    assign wr_addr = line_addr(victim_tag, req_index);

    assign wr_data = victim_line;

endmodule

//--- logic/dcache_top.sv
`timescale 1ns/1ps

module dcache_top (
    input  logic                           clk_g,
    input  logic                           resetn,
    // processor
    input  logic                           req,
    input  logic                           wr,
    input  logic [dcache_pkg::ADDR_W-1:0]  addr,
    input  logic [dcache_pkg::STRB_W-1:0]  wstrb,
    input  dcache_pkg::word_t              wdata,
    output logic                           addr_ok,
    output logic                           data_ok,
    output dcache_pkg::word_t              rdata,
    // memory
    output logic                           rd_req,
    output logic [dcache_pkg::ADDR_W-1:0]  rd_addr,
    input  logic                           rd_rdy,
    input  logic                           ret_valid,
    input  dcache_pkg::line_t              ret_data,
    output logic                           wr_req,
    output logic [dcache_pkg::ADDR_W-1:0]  wr_addr,
    output dcache_pkg::line_t              wr_data,
    input  logic                           wr_rdy,
    input  logic                           wr_bvalid
);

    logic                           pending;
    logic                           req_wr;
    dcache_pkg::tag_t               req_tag;
    dcache_pkg::index_t             req_index;
    dcache_pkg::word_sel_t          req_word;
    logic [dcache_pkg::STRB_W-1:0]  req_wstrb;
    dcache_pkg::word_t              req_wdata;

    logic                           hit;
    logic                           victim_dirty;
    dcache_pkg::tag_t               victim_tag;
    dcache_pkg::line_t              victim_line;

    logic                           lookup_ready;
    logic                           store_en;
    logic                           refill_en;

    dcache_req_stage u_req_stage (
        .clk_g        (clk_g),
        .resetn       (resetn),
        .req          (req),
        .wr           (wr),
        .addr         (addr),
        .wstrb        (wstrb),
        .wdata        (wdata),
        .lookup_ready (lookup_ready),
        .data_ok      (data_ok),
        .addr_ok      (addr_ok),
        .pending      (pending),
        .req_wr       (req_wr),
        .req_tag      (req_tag),
        .req_index    (req_index),
        .req_word     (req_word),
        .req_wstrb    (req_wstrb),
        .req_wdata    (req_wdata)
    );

    dcache_ways u_ways (
        .clk_g        (clk_g),
        .resetn       (resetn),
        .req_tag      (req_tag),
        .req_index    (req_index),
        .req_word     (req_word),
        .req_wstrb    (req_wstrb),
        .req_wdata    (req_wdata),
        .store_en     (store_en),
        .refill_en    (refill_en),
        .ret_data     (ret_data),
        .hit          (hit),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag),
        .victim_line  (victim_line),
        .rd_word      (rdata)
    );

    dcache_ctrl u_ctrl (
        .clk_g        (clk_g),
        .resetn       (resetn),
        .pending      (pending),
        .req_wr       (req_wr),
        .hit          (hit),
        .victim_dirty (victim_dirty),
        .rd_rdy       (rd_rdy),
        .ret_valid    (ret_valid),
        .wr_rdy       (wr_rdy),
        .wr_bvalid    (wr_bvalid),
        .lookup_ready (lookup_ready),
        .store_en     (store_en),
        .refill_en    (refill_en),
        .rd_req       (rd_req),
        .wr_req       (wr_req),
        .data_ok      (data_ok)
    );

    dcache_mem_port u_mem_port (
        .req_tag      (req_tag),
        .req_index    (req_index),
        .victim_tag   (victim_tag),
        .victim_line  (victim_line),
        .rd_addr      (rd_addr),
        .wr_addr      (wr_addr),
        .wr_data      (wr_data)
    );

endmodule

//--- dv/tb_line_mem.sv
`timescale 1ns/1ps

module tb_line_mem (
    input  logic                           clk_g,
    input  logic                           resetn,
    input  logic                           rd_req,
    input  logic [dcache_pkg::ADDR_W-1:0]  rd_addr,
    output logic                           rd_rdy,
    output logic                           ret_valid,
    output dcache_pkg::line_t              ret_data,
    input  logic                           wr_req,
    input  logic [dcache_pkg::ADDR_W-1:0]  wr_addr,
    input  dcache_pkg::line_t              wr_data,
    output logic                           wr_rdy,
    output logic                           wr_bvalid,
    output int                             wb_count,
    output logic [dcache_pkg::ADDR_W-1:0]  wb_addr,
    output dcache_pkg::line_t              wb_line
);

    import dcache_pkg::*;

    localparam int unsigned MEM_BYTES = 8192;

    logic [7:0] mem [MEM_BYTES];

    // idle gap of 0 to 3 cycles
    task automatic wait_random();
        repeat ($urandom_range(0, 3)) @(posedge clk_g);
    endtask

    initial begin
        logic [ADDR_W-1:0] a;
        line_t             line;
        rd_rdy    = 1'b0;
        ret_valid = 1'b0;
        ret_data  = '0;
        wr_rdy    = 1'b0;
        wr_bvalid = 1'b0;
        wb_count  = 0;
        wb_addr   = '0;
        wb_line   = '0;
        // fill uses every address bit of the window
        for (int i = 0; i < MEM_BYTES; i++) begin
            mem[i] = 8'(i) ^ 8'((i >> 8) * 29);
        end
        forever begin
            @(posedge clk_g);
            if (resetn && wr_req) begin
                wait_random();
                wr_rdy <= 1'b1;
                @(posedge clk_g);
                wr_rdy <= 1'b0;
                a = wr_addr;
                for (int b = 0; b < LINE_W / 8; b++) begin
                    mem[(a + b) % MEM_BYTES] = wr_data[8*b +: 8];
                end
                wb_count <= wb_count + 1;
                wb_addr  <= a;
                wb_line  <= wr_data;
                wait_random();
                wr_bvalid <= 1'b1;
                @(posedge clk_g);
                wr_bvalid <= 1'b0;
            end else if (resetn && rd_req) begin
                wait_random();
                rd_rdy <= 1'b1;
                @(posedge clk_g);
                rd_rdy <= 1'b0;
                a = rd_addr;
                for (int b = 0; b < LINE_W / 8; b++) begin
                    line[8*b +: 8] = mem[(a + b) % MEM_BYTES];
                end
                wait_random();
                // whole line in one beat
                ret_valid <= 1'b1;
                ret_data  <= line;
                @(posedge clk_g);
                ret_valid <= 1'b0;
            end
        end
    end

endmodule

//--- dv/tb_dcache.sv
`timescale 1ns/1ps

module tb_dcache;

    import dcache_pkg::*;

    localparam int MAX_CYCLES = 20000;
    localparam int MEM_BYTES  = 8192;

    logic              clk_g;
    logic              resetn;
    logic              req;
    logic              wr;
    logic [ADDR_W-1:0] addr;
    logic [STRB_W-1:0] wstrb;
    word_t             wdata;
    logic              addr_ok;
    logic              data_ok;
    word_t             rdata;
    logic              rd_req;
    logic [ADDR_W-1:0] rd_addr;
    logic              rd_rdy;
    logic              ret_valid;
    line_t             ret_data;
    logic              wr_req;
    logic [ADDR_W-1:0] wr_addr;
    line_t             wr_data;
    logic              wr_rdy;
    logic              wr_bvalid;
    int                wb_count;
    logic [ADDR_W-1:0] wb_addr;
    line_t             wb_line;

    // processor view of memory
    logic [7:0]        ref_mem [MEM_BYTES];
    int                cycles   = 0;
    int                ok_count = 0;
    int                issued   = 0;

    dcache_top u_dut (.*);

    tb_line_mem u_mem (.*);

    initial begin
        clk_g = 1'b0;
        forever #20 clk_g = ~clk_g;
    end

    task automatic abort_run();
        $display("TEST FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    always @(posedge clk_g) begin
        cycles <= cycles + 1;
        if (data_ok) begin
            ok_count <= ok_count + 1;
        end
        if (cycles >= MAX_CYCLES) begin
            $display("timeout, the tests did not finish within %0d cycles", MAX_CYCLES);
            abort_run();
        end
    end

    task automatic check_eq(input string name, input logic [127:0] got,
                            input logic [127:0] exp);
        assert (got === exp) else begin
            $display("Fail %s: got 0x%0h, expected 0x%0h", name, got, exp);
            abort_run();
        end
    endtask

    function automatic logic [ADDR_W-1:0] line_base(input int tag, input int set);
        return (ADDR_W'(tag) << (INDEX_W + OFFSET_W)) | (ADDR_W'(set) << OFFSET_W);
    endfunction

    function automatic word_t ref_word(input logic [ADDR_W-1:0] a);
        word_t w;
        for (int b = 0; b < STRB_W; b++) begin
            w[8*b +: 8] = ref_mem[{a[ADDR_W-1:2], 2'b00} + b];
        end
        return w;
    endfunction

    function automatic line_t ref_line(input logic [ADDR_W-1:0] a);
        line_t l;
        for (int b = 0; b < LINE_W / 8; b++) begin
            l[8*b +: 8] = ref_mem[a + b];
        end
        return l;
    endfunction

    // issues one request and waits for acceptance and then data_ok
    task automatic access(input logic w, input logic [ADDR_W-1:0] a,
                          input logic [STRB_W-1:0] s, input word_t d, output int lat);
        word_t exp;
        req   <= 1'b1;
        wr    <= w;
        addr  <= a;
        wstrb <= s;
        wdata <= d;
        do begin
            @(posedge clk_g);
        end while (!addr_ok);
        req    <= 1'b0;
        issued = issued + 1;
        exp    = ref_word(a);
        for (int b = 0; b < STRB_W; b++) begin
            if (w && s[b]) begin
                ref_mem[{a[ADDR_W-1:2], 2'b00} + b] = d[8*b +: 8];
            end
        end
        lat = 0;
        do begin
            @(posedge clk_g);
            lat = lat + 1;
        end while (!data_ok);
        if (!w) begin
            check_eq("rdata", rdata, exp);
        end
    endtask

    task automatic load_cold_line();
        int lat;
        access(1'b0, line_base(1, 2) + 4, '0, '0, lat);
    endtask

    task automatic merge_partial_store();
        int lat;
        access(1'b1, line_base(1, 2) + 8, 4'b0101, 32'ha1b2_c3d4, lat);
        access(1'b0, line_base(1, 2) + 8, '0, '0, lat);
        check_eq("load latency", lat, 1);
    endtask

    task automatic stream_hit_loads();
        int                lat;
        logic [ADDR_W-1:0] base;
        base = line_base(1, 2);
        // second line in first, so all eight words hit
        access(1'b0, base + 16, '0, '0, lat);
        req  <= 1'b1;
        wr   <= 1'b0;
        addr <= base;
        for (int i = 0; i < 8; i++) begin
            @(posedge clk_g);
            check_eq("addr_ok", addr_ok, 1'b1);
            if (i > 0) begin
                check_eq("data_ok", data_ok, 1'b1);
                check_eq("rdata", rdata, ref_word(base + 4 * (i - 1)));
            end
            addr <= base + 4 * (i + 1);
        end
        req <= 1'b0;
        @(posedge clk_g);
        check_eq("data_ok", data_ok, 1'b1);
        check_eq("rdata", rdata, ref_word(base + 28));
        issued = issued + 8;
    endtask

    task automatic evict_dirty_lru();
        int lat;
        int wb_before;
        wb_before = wb_count;
        access(1'b1, line_base(3, 5) + 4, 4'b1110, 32'h5566_7788, lat);
        access(1'b0, line_base(4, 5), '0, '0, lat);
        // touch tag 3 again, tag 4 becomes least recent
        access(1'b0, line_base(3, 5), '0, '0, lat);
        access(1'b0, line_base(5, 5), '0, '0, lat);
        check_eq("wb_count", wb_count, wb_before);
        access(1'b0, line_base(6, 5), '0, '0, lat);
        check_eq("wb_count", wb_count, wb_before + 1);
        check_eq("wb_addr", wb_addr, line_base(3, 5));
        check_eq("wb_line", wb_line, ref_line(line_base(3, 5)));
        access(1'b0, line_base(3, 5) + 4, '0, '0, lat);
    endtask

    // 4 tags x 4 sets x 4 words
    task automatic random_mix();
        int                lat;
        logic [ADDR_W-1:0] a;
        for (int n = 0; n < 200; n++) begin
            a = line_base(16 + $urandom_range(0, 3), 8 + $urandom_range(0, 3))
                + 4 * $urandom_range(0, 3);
            access(1'($urandom_range(0, 1)), a, 4'($urandom_range(1, 15)), $urandom, lat);
        end
        repeat (2) @(posedge clk_g);
        check_eq("data_ok count", ok_count, issued);
    endtask

    initial begin
        void'($urandom(55229));
        resetn   = 1'b0;
        req      = 1'b0;
        wr       = 1'b0;
        addr     = '0;
        wstrb    = '0;
        wdata    = '0;
        repeat (2) @(posedge clk_g);
        resetn <= 1'b1;
        for (int i = 0; i < MEM_BYTES; i++) begin
            ref_mem[i] = u_mem.mem[i];
        end
        load_cold_line();
        merge_partial_store();
        stream_hit_loads();
        evict_dirty_lru();
        random_mix();
        $display("TEST PASSED");
        $finish;
    end

endmodule

//--- build.f
logic/dcache_pkg.sv
logic/dcache_req_stage.sv
logic/dcache_ways.sv
logic/dcache_ctrl.sv
logic/dcache_mem_port.sv
logic/dcache_top.sv
dv/tb_line_mem.sv
dv/tb_dcache.sv
